//--- source/grad_pkg.sv
package grad_pkg;

    // frame geometry
    localparam int IMG_WIDTH  = 8;
    localparam int IMG_HEIGHT = 8;
    localparam int IMG_PIXELS = IMG_WIDTH * IMG_HEIGHT;
    localparam int COL_W      = $clog2(IMG_WIDTH);

    // memory and datapath widths
    localparam int ADDR_W      = 16;
    localparam int PIXEL_W     = 8;
    localparam int GRAD_W      = 10;
    // gx in the upper half, gy in the lower half
    localparam int GRAD_WORD_W = 2 * GRAD_W;

    typedef enum logic {
        FETCH_IDLE,
        FETCH_READ
    } fetch_state_e;

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_STREAM,
        ENG_FLUSH
    } engine_state_e;

endpackage

//--- source/grad_cfg_pkg.sv
package grad_cfg_pkg;

    localparam int CFG_ADDR_W = 2;
    localparam int CFG_DATA_W = 8;

    // --------------------
    // register map
    typedef enum logic [CFG_ADDR_W-1:0] {
        CTRL   = 2'd0,
        MODE   = 2'd1,
        STATUS = 2'd2
    } cfg_reg_e;

    // CTRL and MODE field positions
    localparam int CTRL_START_BIT  = 0;
    localparam int MODE_BORDER_BIT = 0;

    // what stands in for a neighbour outside the frame
    typedef enum logic {
        BORDER_ZERO      = 1'b0,
        BORDER_REPLICATE = 1'b1
    } border_mode_e;

    // --------------------
    // STATUS bits
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

endpackage

//--- source/grad_cfg_regs.sv
module grad_cfg_regs (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  cfg_wr,
    input  logic [grad_cfg_pkg::CFG_ADDR_W-1:0]   cfg_addr,
    input  logic [grad_cfg_pkg::CFG_DATA_W-1:0]   cfg_wdata,
    input  logic                                  frame_done,
    output logic [grad_cfg_pkg::CFG_DATA_W-1:0]   cfg_rdata,
    output logic                                  start,
    output grad_cfg_pkg::border_mode_e            border_mode
);
    import grad_cfg_pkg::*;

    logic busy_q;
    logic done_q;
    logic wr_ctrl;
    logic wr_mode;
    logic status_busy;
    logic status_done;

    // --------------------
    // write decode
    assign wr_ctrl = cfg_wr && (cfg_reg_e'(cfg_addr) == CTRL);
    assign wr_mode = cfg_wr && (cfg_reg_e'(cfg_addr) == MODE);

    // frame end shows in STATUS on the same edge as the done strobe
    assign status_busy = busy_q && !frame_done;
    assign status_done = done_q || frame_done;

    // a start request while a frame runs is dropped
    assign start = wr_ctrl && cfg_wdata[CTRL_START_BIT] && !status_busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q      <= 1'b0;
            done_q      <= 1'b0;
            border_mode <= BORDER_ZERO;
        end else begin
            if (start) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
            end else if (frame_done) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
            if (wr_mode) begin
                border_mode <= border_mode_e'(cfg_wdata[MODE_BORDER_BIT]);
            end
        end
    end

    // --------------------
    // read mux
    always_comb begin
        cfg_rdata = '0;
        case (cfg_reg_e'(cfg_addr))
            MODE: begin
                cfg_rdata[MODE_BORDER_BIT] = border_mode;
            end
            STATUS: begin
                cfg_rdata[STATUS_BUSY_BIT] = status_busy;
                cfg_rdata[STATUS_DONE_BIT] = status_done;
            end
            // CTRL start bit is self clearing
            default: begin
                cfg_rdata = '0;
            end
        endcase
    end

endmodule

//--- source/pixel_fetch.sv
module pixel_fetch (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start,
    output logic                             img_rd,
    output logic [grad_pkg::ADDR_W-1:0]      img_addr,
    input  logic [grad_pkg::PIXEL_W-1:0]     img_di,
    output logic                             pix_valid,
    output logic [grad_pkg::PIXEL_W-1:0]     pix_data,
    output logic [grad_pkg::ADDR_W-1:0]      pix_index
);
    import grad_pkg::*;

    fetch_state_e       state;
    logic [ADDR_W-1:0]  rd_addr;
    logic               last_addr;

    assign last_addr = (rd_addr == ADDR_W'(IMG_PIXELS - 1));

    // --------------------
    // read sequencer
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= FETCH_IDLE;
            rd_addr <= '0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (start) begin
                        state   <= FETCH_READ;
                        rd_addr <= '0;
                    end
                end
                FETCH_READ: begin
                    if (last_addr) begin
                        state <= FETCH_IDLE;
                    end else begin
                        rd_addr <= rd_addr + 1'b1;
                    end
                end
                default: begin
                    state <= FETCH_IDLE;
                end
            endcase
        end
    end

    // one read per cycle for the whole frame
    assign img_rd   = (state == FETCH_READ);
    assign img_addr = rd_addr;

    // --------------------
    // memory answers one cycle later, so strobe and index follow by one
    always_ff @(posedge clk) begin
        if (reset) begin
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= img_rd;
        end
    end

    always_ff @(posedge clk) begin
        pix_index <= rd_addr;
    end

    assign pix_data = img_di;

endmodule

//--- source/gradient_engine.sv
module gradient_engine (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 start,
    input  grad_cfg_pkg::border_mode_e           border_mode,
    input  logic                                 pix_valid,
    input  logic [grad_pkg::PIXEL_W-1:0]         pix_data,
    input  logic [grad_pkg::ADDR_W-1:0]          pix_index,
    output logic                                 grad_wr,
    output logic [grad_pkg::ADDR_W-1:0]          grad_addr,
    output logic [grad_pkg::GRAD_WORD_W-1:0]     grad_do,
    output logic                                 frame_done
);
    import grad_pkg::*;
    import grad_cfg_pkg::*;

    engine_state_e             state;
    border_mode_e              mode_q;
    logic [PIXEL_W-1:0]        win [0:IMG_WIDTH];
    logic [COL_W-1:0]          col;
    logic [COL_W-1:0]          flush_cnt;
    logic                      shift_en;
    logic [PIXEL_W-1:0]        shift_in;
    logic                      last_col;
    logic                      last_row;
    logic [PIXEL_W-1:0]        border_px;
    logic [PIXEL_W-1:0]        right_px;
    logic [PIXEL_W-1:0]        lower_px;
    logic signed [GRAD_W-1:0]  gx;
    logic signed [GRAD_W-1:0]  gy;

    // --------------------
    // line buffer
    // win[0] is pixel j, win[1] its right neighbour, win[IMG_WIDTH] the one below
    assign shift_en = ((state == ENG_STREAM) && pix_valid) || (state == ENG_FLUSH);
    // past the last row zeros are shifted in
    assign shift_in = (state == ENG_FLUSH) ? '0 : pix_data;

    always_ff @(posedge clk) begin
        if (shift_en) begin
            for (int k = 0; k < IMG_WIDTH; k++) begin
                win[k] <= win[k + 1];
            end
            win[IMG_WIDTH] <= shift_in;
        end
    end

    // --------------------
    // state machine
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ENG_IDLE;
            mode_q    <= BORDER_ZERO;
            flush_cnt <= '0;
        end else begin
            case (state)
                ENG_IDLE: begin
                    if (start) begin
                        state  <= ENG_STREAM;
                        mode_q <= border_mode;
                    end
                end
                ENG_STREAM: begin
                    if (pix_valid && (pix_index == ADDR_W'(IMG_PIXELS - 1))) begin
                        state     <= ENG_FLUSH;
                        flush_cnt <= '0;
                    end
                end
                ENG_FLUSH: begin
                    // one shift per word of the last row
                    flush_cnt <= flush_cnt + 1'b1;
                    if (flush_cnt == COL_W'(IMG_WIDTH - 1)) begin
                        state <= ENG_IDLE;
                    end
                end
                default: begin
                    state <= ENG_IDLE;
                end
            endcase
        end
    end

    // --------------------
    // write sequencing
    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr    <= 1'b0;
            grad_addr  <= '0;
            col        <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= grad_wr && (grad_addr == ADDR_W'(IMG_PIXELS - 1));
            case (state)
                ENG_STREAM: grad_wr <= pix_valid && (pix_index >= ADDR_W'(IMG_WIDTH));
                ENG_FLUSH:  grad_wr <= 1'b1;
                default:    grad_wr <= 1'b0;
            endcase
            if (start) begin
                grad_addr <= '0;
                col       <= '0;
            end else if (grad_wr) begin
                grad_addr <= grad_addr + 1'b1;
                // wraps at the row end
                col       <= col + 1'b1;
            end
        end
    end

    // --------------------
    // difference datapath
    assign last_col  = (col == COL_W'(IMG_WIDTH - 1));
    assign last_row  = (grad_addr >= ADDR_W'(IMG_PIXELS - IMG_WIDTH));
    assign border_px = (mode_q == BORDER_REPLICATE) ? win[0] : '0;
    assign right_px  = last_col ? border_px : win[1];
    assign lower_px  = last_row ? border_px : win[IMG_WIDTH];

    assign gx      = GRAD_W'(right_px) - GRAD_W'(win[0]);
    assign gy      = GRAD_W'(lower_px) - GRAD_W'(win[0]);
    assign grad_do = {gx, gy};

endmodule

//--- source/image_gradient.sv
module image_gradient (
    input  logic                                  clk,
    input  logic                                  reset,
    // register bus
    input  logic                                  cfg_wr,
    input  logic [grad_cfg_pkg::CFG_ADDR_W-1:0]   cfg_addr,
    input  logic [grad_cfg_pkg::CFG_DATA_W-1:0]   cfg_wdata,
    output logic [grad_cfg_pkg::CFG_DATA_W-1:0]   cfg_rdata,
    // image memory
    output logic                                  img_rd,
    output logic [grad_pkg::ADDR_W-1:0]           img_addr,
    input  logic [grad_pkg::PIXEL_W-1:0]          img_di,
    // gradient memory
    output logic                                  grad_wr,
    output logic [grad_pkg::ADDR_W-1:0]           grad_addr,
    output logic [grad_pkg::GRAD_WORD_W-1:0]      grad_do,
    output logic                                  done
);
    import grad_pkg::*;
    import grad_cfg_pkg::*;

    logic               start;
    border_mode_e       border_mode;
    logic               pix_valid;
    logic [PIXEL_W-1:0] pix_data;
    logic [ADDR_W-1:0]  pix_index;
    logic               frame_done;

    grad_cfg_regs u_regs (
        .clk         (clk),
        .reset       (reset),
        .cfg_wr      (cfg_wr),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .frame_done  (frame_done),
        .cfg_rdata   (cfg_rdata),
        .start       (start),
        .border_mode (border_mode)
    );

    pixel_fetch u_fetch (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .pix_index (pix_index)
    );

    gradient_engine u_engine (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .border_mode (border_mode),
        .pix_valid   (pix_valid),
        .pix_data    (pix_data),
        .pix_index   (pix_index),
        .grad_wr     (grad_wr),
        .grad_addr   (grad_addr),
        .grad_do     (grad_do),
        .frame_done  (frame_done)
    );

    // frame end strobe also leaves the chip
    assign done = frame_done;

endmodule

//--- tests/image_gradient_assertions.sv
module image_gradient_assertions (
    input logic                        clk,
    input logic                        reset,
    input logic                        img_rd,
    input logic                        grad_wr,
    input logic [grad_pkg::ADDR_W-1:0] grad_addr,
    input logic                        done
);
    import grad_pkg::*;

    // count of failed assertions
    int fail_count = 0;

    // --------------------
    // strobes
    done_single_cycle: assert property (
        @(posedge clk) disable iff (reset) done |=> !done
    ) else begin
        fail_count++;
        $error("done stayed high for more than one cycle");
    end

    done_apart_from_write: assert property (
        @(posedge clk) disable iff (reset) !(done && grad_wr)
    ) else begin
        fail_count++;
        $error("done and grad_wr high in the same cycle");
    end

    strobes_known: assert property (
        @(posedge clk) disable iff (reset) !$isunknown(img_rd) && !$isunknown(grad_wr)
    ) else begin
        fail_count++;
        $error("img_rd or grad_wr unknown");
    end

    // --------------------
    // gradient memory range
    write_addr_in_frame: assert property (
        @(posedge clk) disable iff (reset) grad_wr |-> (grad_addr < ADDR_W'(IMG_PIXELS))
    ) else begin
        fail_count++;
        $error("gradient write outside the frame");
    end

endmodule

bind image_gradient image_gradient_assertions u_assertions (
    .clk       (clk),
    .reset     (reset),
    .img_rd    (img_rd),
    .grad_wr   (grad_wr),
    .grad_addr (grad_addr),
    .done      (done)
);

//--- tests/image_gradient_tb.sv
module image_gradient_tb;
    import grad_pkg::*;
    import grad_cfg_pkg::*;

    localparam int CLK_HALF     = 50;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 8;
    localparam int WAIT_LIMIT   = 500;
    localparam int IDX_W        = $clog2(IMG_PIXELS);
    localparam logic [CFG_DATA_W-1:0] CTRL_START_CMD = CFG_DATA_W'(1) << CTRL_START_BIT;
    localparam logic [31:0] STATUS_BUSY_VAL = 32'd1 << STATUS_BUSY_BIT;
    localparam logic [31:0] STATUS_DONE_VAL = 32'd1 << STATUS_DONE_BIT;

    logic                   clk;
    logic                   reset;
    logic                   cfg_wr;
    logic [CFG_ADDR_W-1:0]  cfg_addr;
    logic [CFG_DATA_W-1:0]  cfg_wdata;
    logic [CFG_DATA_W-1:0]  cfg_rdata;
    logic                   img_rd;
    logic [ADDR_W-1:0]      img_addr;
    logic [PIXEL_W-1:0]     img_di;
    logic                   grad_wr;
    logic [ADDR_W-1:0]      grad_addr;
    logic [GRAD_WORD_W-1:0] grad_do;
    logic                   done;

    // golden file holds three words per pixel
    logic [GRAD_WORD_W-1:0] golden_mem [0:3*IMG_PIXELS-1];
    logic [PIXEL_W-1:0]     pixel_mem  [0:IMG_PIXELS-1];
    logic [GRAD_WORD_W-1:0] zero_word  [0:IMG_PIXELS-1];
    logic [GRAD_WORD_W-1:0] rep_word   [0:IMG_PIXELS-1];

    // monitor state, cleared at the first read of each frame
    int                     rd_count = 0;
    int                     done_count = 0;
    int                     wr_next = 0;
    int                     wr_count [0:IMG_PIXELS-1];
    logic [GRAD_WORD_W-1:0] capture  [0:IMG_PIXELS-1];
    logic                   rd_prev = 1'b0;
    logic                   wr_prev = 1'b0;
    logic [ADDR_W-1:0]      wr_prev_addr = '0;

    image_gradient uut (
        .clk       (clk),
        .reset     (reset),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // --------------------
    // error handling
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED %s: expected %0h, actual %0h",
                                name, expected, actual));
        end
    endtask

    // --------------------
    // image memory, answers one cycle after each read
    initial begin
        logic              rd_seen;
        logic [ADDR_W-1:0] addr_seen;
        img_di = '0;
        forever begin
            @(negedge clk);
            rd_seen   = img_rd;
            addr_seen = img_addr;
            @(posedge clk);
            #DRIVE_DELAY;
            img_di = rd_seen ? pixel_mem[addr_seen[IDX_W-1:0]] : '0;
        end
    end

    // --------------------
    // bus monitor, samples mid cycle
    always @(negedge clk) begin
        if (!reset) begin
            check_value("assertion failures", 32'd0, 32'(uut.u_assertions.fail_count));
            if (img_rd && !rd_prev) begin
                rd_count   = 0;
                done_count = 0;
                wr_next    = 0;
                for (int i = 0; i < IMG_PIXELS; i++) begin
                    wr_count[i] = 0;
                    capture[i]  = '0;
                end
            end
            if (img_rd) begin
                check_value("read address", 32'(rd_count), 32'(img_addr));
                rd_count++;
            end
            if (!img_rd && rd_prev) begin
                check_value("read burst length", 32'(IMG_PIXELS), 32'(rd_count));
            end
            if (grad_wr) begin
                check_value("write order", 32'(wr_next), 32'(grad_addr));
                capture[grad_addr[IDX_W-1:0]]  = grad_do;
                wr_count[grad_addr[IDX_W-1:0]] = wr_count[grad_addr[IDX_W-1:0]] + 1;
                wr_next++;
            end
            if (done) begin
                // done follows the write of the last address
                check_value("done timing", 32'd1,
                            32'(wr_prev && (wr_prev_addr == ADDR_W'(IMG_PIXELS - 1))));
                done_count++;
            end
        end
        rd_prev      = img_rd;
        wr_prev      = grad_wr;
        wr_prev_addr = grad_addr;
    end

    // --------------------
    // register access and waits
    task automatic write_reg(input cfg_reg_e addr, input logic [CFG_DATA_W-1:0] data);
        @(posedge clk);
        #DRIVE_DELAY;
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clk);
        #DRIVE_DELAY;
        cfg_wr    = 1'b0;
    endtask

    task automatic read_reg(input cfg_reg_e addr, output logic [CFG_DATA_W-1:0] data);
        @(posedge clk);
        #DRIVE_DELAY;
        cfg_addr = addr;
        @(negedge clk);
        data = cfg_rdata;
    endtask

    task automatic wait_for_reads(input int count);
        int cycles;
        cycles = 0;
        while (rd_count < count) begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run("image reads stopped before the expected count");
            end
        end
    endtask

    task automatic wait_for_done(input string name);
        int cycles;
        cycles = 0;
        while (done_count == 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run({name, ": no done strobe before the timeout"});
            end
        end
    endtask

    // --------------------
    // test sequences
    task automatic load_golden();
        $readmemh("tests/image_gradient_golden.txt", golden_mem);
        for (int i = 0; i < IMG_PIXELS; i++) begin
            pixel_mem[i] = golden_mem[3 * i][PIXEL_W-1:0];
            zero_word[i] = golden_mem[3 * i + 1];
            rep_word[i]  = golden_mem[3 * i + 2];
        end
        if ($isunknown(golden_mem[3 * IMG_PIXELS - 1])) begin
            abort_run("golden file could not be read completely");
        end
    endtask

    task automatic check_reset_state();
        logic [CFG_DATA_W-1:0] data;
        @(negedge clk);
        check_value("reset img_rd", 32'd0, 32'(img_rd));
        check_value("reset grad_wr", 32'd0, 32'(grad_wr));
        check_value("reset done", 32'd0, 32'(done));
        read_reg(STATUS, data);
        check_value("reset status", 32'd0, 32'(data));
        read_reg(MODE, data);
        check_value("reset mode", 32'(BORDER_ZERO), 32'(data));
    endtask

    task automatic check_frame(input string name, input border_mode_e mode);
        logic [GRAD_WORD_W-1:0] expected;
        for (int i = 0; i < IMG_PIXELS; i++) begin
            expected = (mode == BORDER_REPLICATE) ? rep_word[i] : zero_word[i];
            check_value($sformatf("%s writes to %0d", name, i), 32'd1, 32'(wr_count[i]));
            check_value($sformatf("%s word %0d", name, i), 32'(expected), 32'(capture[i]));
        end
    endtask

    task automatic run_frame(input string name, input border_mode_e mode, input bit restart);
        logic [CFG_DATA_W-1:0] status;
        write_reg(MODE, CFG_DATA_W'(mode));
        write_reg(CTRL, CTRL_START_CMD);
        // start also clears the sticky done
        read_reg(STATUS, status);
        check_value({name, " status while running"}, STATUS_BUSY_VAL, 32'(status));
        if (restart) begin
            wait_for_reads(IMG_PIXELS / 3);
            write_reg(CTRL, CTRL_START_CMD);
            read_reg(STATUS, status);
            check_value({name, " status after second start"}, STATUS_BUSY_VAL, 32'(status));
        end
        wait_for_done(name);
        repeat (4) @(posedge clk);
        check_value({name, " read count"}, 32'(IMG_PIXELS), 32'(rd_count));
        check_value({name, " done pulses"}, 32'd1, 32'(done_count));
        read_reg(STATUS, status);
        check_value({name, " status at end"}, STATUS_DONE_VAL, 32'(status));
        check_frame(name, mode);
    endtask

    initial begin
        reset     = 1'b1;
        cfg_wr    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        load_golden();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;

        check_reset_state();
        run_frame("zero mode", BORDER_ZERO, 1'b0);
        run_frame("replicate mode", BORDER_REPLICATE, 1'b0);
        run_frame("start while busy", BORDER_ZERO, 1'b1);
        check_value("assertion failures", 32'd0, 32'(uut.u_assertions.fail_count));

        $display("Test OK");
        $finish;
    end

endmodule

//--- tests/image_gradient_golden.txt
// pixel, expected word in zero mode, expected word in replicate mode (hex)
// one line per pixel in raster order, word is gx in bits 19:10 and gy in bits 9:0
0F 0DC5A 0DC5A
46 F605A F605A
1E 1A45A 1A45A
87 F745A F745A
64 0785A 0785A
82 E985A E985A
28 1185A 1185A
6E E485A 0005A
69 0DFC4 0DFC4
A0 F63C4 F63C4
78 1A7C4 1A7C4
E1 F77C4 F77C4
BE 07BC4 07BC4
DC E9BC4 E9BC4
82 11BC4 11BC4
C8 CE3C4 003C4
2D 0DC5A 0DC5A
64 F605A F605A
3C 1A45A 1A45A
A5 F745A F745A
82 0785A 0785A
A0 E985A E985A
46 1185A 1185A
8C DD05A 0005A
87 0DF7E 0DF7E
BE F637E F637E
96 1A77E 1A77E
FF F777E F777E
DC 07B7E 07B7E
FA E9B7E E9B7E
A0 11B7E 11B7E
E6 C6B7E 0037E
05 0DC46 0DC46
3C F6046 F6046
14 1A446 1A446
7D F7446 F7446
5A 07846 07846
78 E9846 E9846
1E 11846 11846
64 E7046 00046
4B 0DFCE 0DFCE
82 F63CE F63CE
5A 1A7CE 1A7CE
C3 F77CE F77CE
A0 07BCE 07BCE
BE E9BCE E9BCE
64 11BCE 11BCE
AA D5BCE 003CE
19 0DC5A 0DC5A
50 F605A F605A
28 1A45A 1A45A
91 F745A F745A
6E 0785A 0785A
8C E985A E985A
32 1185A 1185A
78 E205A 0005A
73 0DF8D 0DC00
AA F6356 F6000
82 1A77E 1A400
EB F7715 F7400
C8 07B38 07800
E6 E9B1A E9800
8C 11B74 11800
D2 CBB2E 00000

//--- vlog.f
source/grad_pkg.sv
source/grad_cfg_pkg.sv
source/grad_cfg_regs.sv
source/pixel_fetch.sv
source/gradient_engine.sv
source/image_gradient.sv
tests/image_gradient_assertions.sv
tests/image_gradient_tb.sv

//--- Makefile
TB_TOP = image_gradient_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module image_gradient -f vlog.f

sim:
	verilator --binary --timing --assert --top-module $(TB_TOP) -f vlog.f -o $(TB_TOP)
	./obj_dir/$(TB_TOP) | tee sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
